//--- design/udp_axi_pkg.sv
package udp_axi_pkg;

    typedef logic [31:0] word_t;      // one udp or axi data word
    typedef logic [31:0] axi_addr_t;  // byte address
    typedef logic [7:0]  axi_len_t;   // beats minus one
    typedef logic [3:0]  axi_id_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [3:0]  axi_strb_t;  // one bit per byte lane
    typedef logic [7:0]  mark_t;      // top byte of a packet's first word

    localparam mark_t      MARK_HEAD  = 8'h00; // command packet
    localparam mark_t      MARK_DATA  = 8'hFF; // write payload packet
    localparam axi_burst_t BURST_INCR = 2'b01;

    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
    } axi_cmd_t;                      // command fifo entry, 44 bits

    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_burst_t burst;
    } axi_aw_t;                       // 46 bits

    typedef axi_aw_t axi_ar_t;        // read address has the same layout

    typedef struct packed {
        word_t     data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;                        // 37 bits

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;                        // 6 bits

    typedef struct packed {
        axi_id_t   id;
        word_t     data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;                        // 39 bits

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                         gmii_rx_clk,
    input  logic                         rstn,
    input  logic                         push,
    input  logic                         pop,
    input  logic [WIDTH-1:0]             wdata,
    output logic [WIDTH-1:0]             rdata,  // head word, valid when not empty
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   count   // words held
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];        // storage, no reset needed
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1; // wrap for any depth
    endfunction

    assign rdata = mem[rd_ptr];           // show-ahead
    assign empty = (count == '0);
    assign full  = (count == DEPTH);

    always_ff @(posedge gmii_rx_clk) begin
        if (push) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    a_no_overflow:  assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        push |-> !full);                      // producer must watch space
    a_no_underflow: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        pop |-> !empty);

endmodule

//--- design/udp_cmd_parser.sv
`timescale 1ns/1ps

module udp_cmd_parser
    import udp_axi_pkg::*;
(
    input  logic     gmii_rx_clk,
    input  logic     rstn,
    input  logic     udp_rx_en,     // word strobe
    input  logic     udp_rx_done,   // last word of packet, with udp_rx_en
    input  word_t    udp_rx_data,
    output axi_cmd_t wr_cmd,
    output axi_cmd_t rd_cmd,
    output logic     wr_cmd_push,
    output logic     rd_cmd_push,
    output logic     data_push,
    output word_t    data_word
);

    typedef enum logic [2:0] {
        idle,       // waiting for first word of a packet
        head_w0,    // next word is command word 0
        head_w1,    // next word is the address
        payload,    // forwarding write data
        skip        // unknown marker, drop to end
    } parser_state_e;

    parser_state_e state;
    word_t         w0_q;            // held command word 0
    axi_cmd_t      cmd_q;           // decoded command, shared by both fifos
    mark_t         marker;

    assign marker = udp_rx_data[31:24];
    assign wr_cmd = cmd_q;          // push strobe picks the fifo
    assign rd_cmd = cmd_q;

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state       <= idle;
            wr_cmd_push <= 1'b0;
            rd_cmd_push <= 1'b0;
            data_push   <= 1'b0;
        end else begin
            wr_cmd_push <= 1'b0;    // strobes are single cycle
            rd_cmd_push <= 1'b0;
            data_push   <= 1'b0;
            if (udp_rx_en) begin
                case (state)
                    idle: begin
                        if (udp_rx_done)
                            state <= idle;          // one-word packet, nothing to do
                        else if (marker == MARK_HEAD)
                            state <= head_w1;       // marker word doubles as word 0
                        else if (marker == MARK_DATA)
                            state <= payload;       // marker itself is dropped
                        else
                            state <= skip;
                    end
                    head_w0: begin
                        state <= udp_rx_done ? idle : head_w1;
                    end
                    head_w1: begin
                        wr_cmd_push <= w0_q[20];    // bit 20 selects write
                        rd_cmd_push <= !w0_q[20];
                        state       <= udp_rx_done ? idle : head_w0;
                    end
                    payload: begin
                        data_push <= 1'b1;
                        state     <= udp_rx_done ? idle : payload;
                    end
                    skip: begin
                        if (udp_rx_done) state <= idle;
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // payload registers, qualified by the strobes above
    always_ff @(posedge gmii_rx_clk) begin
        if (udp_rx_en && (state == idle || state == head_w0))
            w0_q <= udp_rx_data;
        if (udp_rx_en && state == head_w1)
            cmd_q <= '{id: w0_q[19:16], addr: udp_rx_data, len: w0_q[7:0]};
        if (udp_rx_en)
            data_word <= udp_rx_data;   // pushed only when data_push follows
    end

    // the mac side must flag the last word on a valid beat
    a_done_with_en: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        udp_rx_done |-> udp_rx_en);

endmodule

//--- design/axi_wr_master.sv
`timescale 1ns/1ps

module axi_wr_master
    import udp_axi_pkg::*;
#(
    parameter int DATA_DEPTH = 512
) (
    input  logic                              gmii_rx_clk,
    input  logic                              rstn,
    input  axi_cmd_t                          cmd,         // head of write cmd fifo
    input  logic                              cmd_empty,
    output logic                              cmd_pop,
    input  word_t                             data_word,   // head of payload fifo
    input  logic [$clog2(DATA_DEPTH+1)-1:0]   data_count,
    output logic                              data_pop,
    output axi_aw_t                           aw,
    output logic                              aw_valid,
    input  logic                              aw_ready,
    output axi_w_t                            w,
    output logic                              w_valid,
    input  logic                              w_ready,
    input  axi_b_t                            b,
    input  logic                              b_valid,
    output logic                              b_ready
);

    typedef enum logic [1:0] {idle, addr, data, resp} wr_state_e;

    wr_state_e  state;
    axi_len_t   beat_cnt;           // beats sent in this burst
    logic [8:0] need;               // words the head command consumes
    logic       start;

    assign need  = {1'b0, cmd.len} + 9'd1;
    assign start = (state == idle) && !cmd_empty && (data_count >= need); // whole burst buffered

    assign cmd_pop  = start;
    assign aw_valid = (state == addr);
    assign w_valid  = (state == data);
    assign w        = '{data: data_word, strb: '1, last: (beat_cnt == aw.len)};
    assign data_pop = w_valid && w_ready;   // one word per handshake
    assign b_ready  = (state == resp);

    always_ff @(posedge gmii_rx_clk) begin
        if (start) aw <= '{id: cmd.id, addr: cmd.addr, len: cmd.len, burst: BURST_INCR};
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state    <= idle;
            beat_cnt <= '0;
        end else begin
            case (state)
                idle: if (start) state <= addr;
                addr: begin
                    if (aw_ready) begin
                        state    <= data;
                        beat_cnt <= '0;
                    end
                end
                data: begin
                    if (w_ready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (w.last) state <= resp;
                    end
                end
                resp: if (b_valid) state <= idle;   // response code ignored
                default: state <= idle;
            endcase
        end
    end

    a_aw_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw));
    a_w_last_ends: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        w_valid && w_ready && w.last |=> !w_valid && b_ready);
    a_b_id: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        b_valid && b_ready |-> b.id == aw.id);

endmodule

//--- design/axi_rd_master.sv
`timescale 1ns/1ps

module axi_rd_master
    import udp_axi_pkg::*;
(
    input  logic     gmii_rx_clk,
    input  logic     rstn,
    input  axi_cmd_t cmd,           // head of read cmd fifo
    input  logic     cmd_empty,
    output logic     cmd_pop,
    output axi_ar_t  ar,
    output logic     ar_valid,
    input  logic     ar_ready,
    input  axi_r_t   r,
    input  logic     r_valid,
    output logic     r_ready,
    input  logic     tx_full,
    output logic     tx_push,
    output word_t    tx_word,
    output logic     udp_tx_start   // one cycle after the last r beat
);

    typedef enum logic [1:0] {idle, addr, data} rd_state_e;

    rd_state_e state;
    logic      beat;                // accepted r beat

    assign cmd_pop  = (state == idle) && !cmd_empty;
    assign ar_valid = (state == addr);
    assign r_ready  = (state == data) && !tx_full;  // stall on full tx fifo
    assign beat     = r_valid && r_ready;
    assign tx_push  = beat;
    assign tx_word  = r.data;       // resp ignored

    always_ff @(posedge gmii_rx_clk) begin
        if (cmd_pop) ar <= '{id: cmd.id, addr: cmd.addr, len: cmd.len, burst: BURST_INCR};
    end

    always_ff @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            state        <= idle;
            udp_tx_start <= 1'b0;
        end else begin
            udp_tx_start <= 1'b0;
            case (state)
                idle: if (cmd_pop) state <= addr;
                addr: if (ar_ready) state <= data;
                data: begin
                    if (beat && r.last) begin
                        state        <= idle;
                        udp_tx_start <= 1'b1;  // whole burst now in tx fifo
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    a_ar_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));
    // slave must answer with the id of the burst in flight
    a_r_id: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
        beat |-> r.id == ar.id);

endmodule

//--- design/udp_axi_bridge.sv
`timescale 1ns/1ps

module udp_axi_bridge
    import udp_axi_pkg::*;
#(
    parameter int CMD_DEPTH  = 16,   // per command fifo
    parameter int DATA_DEPTH = 512   // payload and tx fifos
) (
    input  logic    gmii_rx_clk,
    input  logic    rstn,
    input  logic    udp_rx_en,
    input  logic    udp_rx_done,
    input  word_t   udp_rx_data,
    input  logic    udp_tx_req,     // pops one tx word
    output logic    udp_tx_start,
    output word_t   udp_tx_data,
    output axi_aw_t aw,
    output logic    aw_valid,
    input  logic    aw_ready,
    output axi_w_t  w,
    output logic    w_valid,
    input  logic    w_ready,
    input  axi_b_t  b,
    input  logic    b_valid,
    output logic    b_ready,
    output axi_ar_t ar,
    output logic    ar_valid,
    input  logic    ar_ready,
    input  axi_r_t  r,
    input  logic    r_valid,
    output logic    r_ready
);

    localparam int CMD_W  = $bits(axi_cmd_t);
    localparam int DCNT_W = $clog2(DATA_DEPTH + 1);

    axi_cmd_t          wr_cmd_in, rd_cmd_in;       // parser side
    axi_cmd_t          wr_cmd_head, rd_cmd_head;   // master side
    logic              wr_cmd_push, rd_cmd_push, wr_cmd_pop, rd_cmd_pop;
    logic              wr_cmd_empty, rd_cmd_empty;
    logic              pay_push, pay_pop;
    word_t             pay_in, pay_head;
    logic [DCNT_W-1:0] pay_count;                  // write master waits on this
    logic              tx_push, tx_full;
    word_t             tx_word;

    udp_cmd_parser i_parser (
        .gmii_rx_clk (gmii_rx_clk), .rstn (rstn),
        .udp_rx_en (udp_rx_en), .udp_rx_done (udp_rx_done), .udp_rx_data (udp_rx_data),
        .wr_cmd (wr_cmd_in), .rd_cmd (rd_cmd_in),
        .wr_cmd_push (wr_cmd_push), .rd_cmd_push (rd_cmd_push),
        .data_push (pay_push), .data_word (pay_in));

    sync_fifo #(.WIDTH(CMD_W), .DEPTH(CMD_DEPTH)) i_wr_cmd_fifo (
        .gmii_rx_clk (gmii_rx_clk), .rstn (rstn), .push (wr_cmd_push), .pop (wr_cmd_pop),
        .wdata (wr_cmd_in), .rdata (wr_cmd_head), .empty (wr_cmd_empty), .full (), .count ());

    sync_fifo #(.WIDTH(CMD_W), .DEPTH(CMD_DEPTH)) i_rd_cmd_fifo (
        .gmii_rx_clk (gmii_rx_clk), .rstn (rstn), .push (rd_cmd_push), .pop (rd_cmd_pop),
        .wdata (rd_cmd_in), .rdata (rd_cmd_head), .empty (rd_cmd_empty), .full (), .count ());

    sync_fifo #(.WIDTH($bits(word_t)), .DEPTH(DATA_DEPTH)) i_pay_fifo (
        .gmii_rx_clk (gmii_rx_clk), .rstn (rstn), .push (pay_push), .pop (pay_pop),
        .wdata (pay_in), .rdata (pay_head), .empty (), .full (), .count (pay_count));

    sync_fifo #(.WIDTH($bits(word_t)), .DEPTH(DATA_DEPTH)) i_tx_fifo (
        .gmii_rx_clk (gmii_rx_clk), .rstn (rstn), .push (tx_push), .pop (udp_tx_req),
        .wdata (tx_word), .rdata (udp_tx_data), .empty (), .full (tx_full), .count ());

    axi_wr_master #(.DATA_DEPTH(DATA_DEPTH)) i_wr_master (
        .gmii_rx_clk (gmii_rx_clk), .rstn (rstn),
        .cmd (wr_cmd_head), .cmd_empty (wr_cmd_empty), .cmd_pop (wr_cmd_pop),
        .data_word (pay_head), .data_count (pay_count), .data_pop (pay_pop),
        .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
        .w (w), .w_valid (w_valid), .w_ready (w_ready),
        .b (b), .b_valid (b_valid), .b_ready (b_ready));

    axi_rd_master i_rd_master (
        .gmii_rx_clk (gmii_rx_clk), .rstn (rstn),
        .cmd (rd_cmd_head), .cmd_empty (rd_cmd_empty), .cmd_pop (rd_cmd_pop),
        .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
        .r (r), .r_valid (r_valid), .r_ready (r_ready),
        .tx_full (tx_full), .tx_push (tx_push), .tx_word (tx_word),
        .udp_tx_start (udp_tx_start));

endmodule

//--- testbench/udp_axi_checker.sv
`timescale 1ns/1ps

module udp_axi_checker
    import udp_axi_pkg::*;
(
    input logic    gmii_rx_clk,
    input logic    rstn,
    input logic    udp_rx_en,
    input logic    udp_rx_done,
    input logic    udp_tx_req,
    input logic    udp_tx_start,
    input word_t   udp_tx_data,
    input axi_aw_t aw,
    input logic    aw_valid, aw_ready,
    input axi_w_t  w,
    input logic    w_valid, w_ready,
    input logic    b_valid, b_ready,
    input axi_ar_t ar,
    input logic    ar_valid, ar_ready,
    input logic    r_ready
);

    axi_aw_t  exp_aw [$];
    word_t    exp_w [$];
    axi_ar_t  exp_ar [$];
    word_t    exp_tx [$];
    axi_aw_t  want_a;
    word_t    want_d;
    axi_len_t w_len;      // len of the burst in flight
    int       w_beat;
    int       b_owed;     // finished write bursts still awaiting B
    logic     rx_busy;    // packet started, last word not yet seen
    int       exp_start, seen_start, test_errors, passed, failed;

    task automatic mismatch(input string sig, input logic [63:0] want, input logic [63:0] got);
        $display("Mismatch at %0d ns: %s expected %0h, got %0h", $time, sig, want, got);
        test_errors++;
    endtask

    task automatic fault(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic expect_aw(input axi_aw_t a);
        exp_aw.push_back(a);
    endtask

    task automatic expect_ar(input axi_ar_t a);
        exp_ar.push_back(a);
    endtask

    task automatic push_w_word(input word_t d);
        exp_w.push_back(d);
    endtask

    task automatic push_tx_word(input word_t d);
        exp_tx.push_back(d);
    endtask

    task automatic expect_start();
        exp_start++;
    endtask

    task automatic check_reset_state();
        if (aw_valid || w_valid || b_ready || ar_valid || r_ready || udp_tx_start)
            fault("a valid, ready or start output is high after reset");
    endtask

    always @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            rx_busy <= 1'b0;
            w_beat  <= 0;
        end else begin
            if (udp_rx_en) rx_busy <= !udp_rx_done;
            if (aw_valid && rx_busy) fault("aw_valid rose while a packet was still arriving");
            if (aw_valid && aw_ready) begin
                if (exp_aw.size() == 0) begin
                    fault("AW handshake that no command asked for");
                end else begin
                    want_a = exp_aw.pop_front();
                    if (aw !== want_a) mismatch("aw", want_a, aw);
                    w_len <= want_a.len;    // burst length as commanded
                end
                w_beat <= 0;
            end
            if (w_valid && w_ready) begin
                if (exp_w.size() == 0) begin
                    fault("W beat with no payload word left");
                end else begin
                    want_d = exp_w.pop_front();
                    if (w.data !== want_d) mismatch("w.data", want_d, w.data);
                end
                if (w.strb !== 4'hF) mismatch("w.strb", 64'hF, w.strb);
                if (w.last !== (w_beat == int'(w_len)))
                    mismatch("w.last", w_beat == int'(w_len), w.last);
                if (w_beat == int'(w_len)) b_owed++;   // burst done, response due
                w_beat <= w_beat + 1;
            end
            if (b_valid && b_ready) begin
                if (b_owed == 0)
                    fault("B handshake with no finished write burst");
                else
                    b_owed--;
            end
            if (ar_valid && ar_ready) begin
                if (exp_ar.size() == 0) begin
                    fault("AR handshake that no command asked for");
                end else begin
                    want_a = exp_ar.pop_front();
                    if (ar !== want_a) mismatch("ar", want_a, ar);
                end
            end
            if (udp_tx_req) begin
                if (exp_tx.size() == 0) begin
                    fault("udp_tx_req popped a word that no read produced");
                end else begin
                    want_d = exp_tx.pop_front();
                    if (udp_tx_data !== want_d) mismatch("udp_tx_data", want_d, udp_tx_data);
                end
            end
            if (udp_tx_start) seen_start++;
        end
    end

    task automatic end_test(input string name);
        if (exp_aw.size() != 0 || exp_w.size() != 0 || exp_ar.size() != 0 || exp_tx.size() != 0)
            fault("expected AXI or UDP traffic never appeared");
        if (seen_start != exp_start) mismatch("udp_tx_start pulses", exp_start, seen_start);
        if (b_owed != 0)
            fault("a write burst ended without an accepted B response");
        if (test_errors == 0) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
        seen_start  = 0;
        exp_start   = 0;
        b_owed      = 0;
    endtask

    task automatic report();
        $display("%0d tests run: %0d passed, %0d failed", passed + failed, passed, failed);
    endtask

endmodule

//--- testbench/tb_udp_axi_bridge.sv
`timescale 1ns/1ps

module tb_udp_axi_bridge
    import udp_axi_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 300;  // budget per table entry, reset counts as one more

    typedef enum logic [1:0] {wr_rd, dual, bad} kind_e;

    typedef struct packed {
        kind_e     kind;     // write then read back, write and read in one header, bad marker
        logic      gaps;     // random ready and valid gaps in the memory model
        mark_t     mark;     // marker of a bad packet
        axi_id_t   id;       // write id, the read uses id + 1
        axi_addr_t addr;     // write address
        axi_len_t  len;
        axi_addr_t rd_addr;  // read address of a dual entry
        word_t     base;     // first payload word, then base + 1 ...
    } test_t;

    test_t tests [NUM_TESTS] = '{
        '{wr_rd, 1'b0, MARK_HEAD, 4'd3,  32'h0000_1000, 8'd3,  32'h0,          32'hA000_0000},
        '{dual,  1'b0, MARK_HEAD, 4'd5,  32'h0000_2000, 8'd1,  32'h0000_3000, 32'hB000_0000},
        '{bad,   1'b0, 8'h5A,     4'd0,  32'h0000_7000, 8'd2,  32'h0,          32'h0},
        '{wr_rd, 1'b1, MARK_HEAD, 4'd9,  32'h0000_4000, 8'd15, 32'h0,          32'hC000_0000},
        '{dual,  1'b1, MARK_HEAD, 4'd12, 32'h0000_5000, 8'd4,  32'h0000_6004, 32'hD000_0000}
    };

    logic      gmii_rx_clk, rstn, udp_rx_en, udp_rx_done, udp_tx_req, udp_tx_start;
    word_t     udp_rx_data, udp_tx_data;
    axi_aw_t   aw;
    logic      aw_valid, aw_ready;
    axi_w_t    w;
    logic      w_valid, w_ready;
    axi_b_t    b;
    logic      b_valid, b_ready;
    axi_ar_t   ar;
    logic      ar_valid, ar_ready;
    axi_r_t    r;
    logic      r_valid, r_ready;

    word_t     mem [axi_addr_t];     // slave memory, sparse
    word_t     pkt [$];              // packet being built
    axi_addr_t wa, ra;
    axi_id_t   wid, rid;
    axi_len_t  rlen;
    int        wbeat, rbeat;
    logic      b_pend, r_busy, gaps_on;
    integer    seed = 69;

    udp_axi_bridge #(.CMD_DEPTH(16), .DATA_DEPTH(512)) i_udp_axi_bridge (.*);
    udp_axi_checker i_udp_axi_checker (.*);

    initial begin
        gmii_rx_clk = 1'b0;
        forever #(CLK_PERIOD / 2) gmii_rx_clk = ~gmii_rx_clk;
    end

    function automatic word_t fill(input axi_addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5AA5_3CC3;  // never-written words
    endfunction

    function automatic word_t rd_word(input axi_addr_t a);
        return mem.exists(a) ? mem[a] : fill(a);
    endfunction

    function automatic logic gap();
        return gaps_on && (($random(seed) & 1) == 0);  // half the cycles stall
    endfunction

    // AXI slave memory model, one burst per direction
    always @(posedge gmii_rx_clk or negedge rstn) begin
        if (!rstn) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            ar_ready <= 1'b0;
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
            b        <= '0;
            r        <= '0;
            b_pend   <= 1'b0;
            r_busy   <= 1'b0;
        end else begin
            aw_ready <= !gap();
            w_ready  <= !gap();
            ar_ready <= !gap();
            if (aw_valid && aw_ready) begin
                wa    <= aw.addr;
                wid   <= aw.id;
                wbeat <= 0;
            end
            if (w_valid && w_ready) begin
                mem[wa + axi_addr_t'(4 * wbeat)] = w.data;  // INCR, 4 bytes per beat
                wbeat <= wbeat + 1;
                if (w.last) b_pend <= 1'b1;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end else if (b_pend && !b_valid && !gap()) begin
                b_valid <= 1'b1;
                b       <= '{id: wid, resp: 2'b00};
                b_pend  <= 1'b0;
            end
            if (ar_valid && ar_ready) begin
                ra     <= ar.addr;
                rid    <= ar.id;
                rlen   <= ar.len;
                rbeat  <= 0;
                r_busy <= 1'b1;
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                if (r.last) r_busy <= 1'b0;
            end
            if (r_busy && (!r_valid || r_ready) && rbeat <= int'(rlen) && !gap()) begin
                r_valid <= 1'b1;    // next beat, held until r_ready
                r       <= '{id: rid, data: rd_word(ra + axi_addr_t'(4 * rbeat)),
                             resp: 2'b00, last: (rbeat == int'(rlen))};
                rbeat   <= rbeat + 1;
            end
        end
    end

    task automatic send_pkt();
        foreach (pkt[i]) begin
            @(posedge gmii_rx_clk);
            udp_rx_en   <= 1'b1;
            udp_rx_done <= (i == pkt.size() - 1);  // flag on the last word
            udp_rx_data <= pkt[i];
        end
        @(posedge gmii_rx_clk);
        udp_rx_en   <= 1'b0;
        udp_rx_done <= 1'b0;
        pkt.delete();
    endtask

    task automatic add_cmd(input logic wr, input axi_id_t id, input axi_addr_t addr,
                           input axi_len_t len);
        axi_aw_t exp;
        exp = '{id: id, addr: addr, len: len, burst: BURST_INCR};
        pkt.push_back({MARK_HEAD, 3'b000, wr, id, 8'h00, len});  // word 0
        pkt.push_back(addr);
        if (wr) begin
            i_udp_axi_checker.expect_aw(exp);
        end else begin
            i_udp_axi_checker.expect_ar(exp);
            i_udp_axi_checker.expect_start();  // one pulse per read burst
        end
    endtask

    task automatic add_payload(input word_t base, input axi_len_t len);
        pkt.push_back({MARK_DATA, 24'h000000});  // marker word, dropped
        for (int i = 0; i <= int'(len); i++) begin
            pkt.push_back(base + word_t'(i));
            i_udp_axi_checker.push_w_word(base + word_t'(i));
        end
    endtask

    task automatic wait_done(input logic need_b, input logic need_start);
        logic got_b;
        logic got_s;
        got_b = !need_b;
        got_s = !need_start;
        while (!(got_b && got_s)) begin
            @(posedge gmii_rx_clk);
            if (b_valid && b_ready) got_b = 1'b1;
            if (udp_tx_start) got_s = 1'b1;
        end
    endtask

    task automatic pop_words(input int n);
        repeat (n) begin
            @(posedge gmii_rx_clk);
            udp_tx_req <= 1'b1;
        end
        @(posedge gmii_rx_clk);
        udp_tx_req <= 1'b0;
    endtask

    initial begin
        test_t cur;
        rstn        = 1'b0;
        udp_rx_en   = 1'b0;
        udp_rx_done = 1'b0;
        udp_rx_data = '0;
        udp_tx_req  = 1'b0;
        gaps_on     = 1'b0;
        repeat (10) @(posedge gmii_rx_clk);
        rstn <= 1'b1;
        repeat (5) @(posedge gmii_rx_clk);
        @(negedge gmii_rx_clk);
        i_udp_axi_checker.check_reset_state();
        i_udp_axi_checker.end_test("reset");
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur     = tests[t];
            gaps_on = cur.gaps;
            case (cur.kind)
                wr_rd: begin
                    add_cmd(1'b1, cur.id, cur.addr, cur.len);
                    send_pkt();
                    add_payload(cur.base, cur.len);
                    send_pkt();
                    wait_done(1'b1, 1'b0);  // data in memory before reading back
                    add_cmd(1'b0, cur.id + 4'd1, cur.addr, cur.len);
                    for (int i = 0; i <= int'(cur.len); i++)
                        i_udp_axi_checker.push_tx_word(cur.base + word_t'(i));
                    send_pkt();
                    wait_done(1'b0, 1'b1);
                    pop_words(int'(cur.len) + 1);
                end
                dual: begin
                    add_cmd(1'b1, cur.id, cur.addr, cur.len);
                    add_cmd(1'b0, cur.id + 4'd1, cur.rd_addr, cur.len);
                    for (int i = 0; i <= int'(cur.len); i++)
                        i_udp_axi_checker.push_tx_word(fill(cur.rd_addr + axi_addr_t'(4 * i)));
                    send_pkt();
                    add_payload(cur.base, cur.len);
                    fork
                        send_pkt();
                        wait_done(1'b1, 1'b1);  // read may finish while data arrives
                    join
                    pop_words(int'(cur.len) + 1);
                end
                default: begin
                    pkt.push_back({cur.mark, 24'h00_0002});  // looks like a read command
                    pkt.push_back(cur.addr);
                    pkt.push_back(32'h0);
                    send_pkt();
                    repeat (TEST_CYCLES / 4) @(posedge gmii_rx_clk);
                end
            endcase
            repeat (4) @(posedge gmii_rx_clk);
            @(negedge gmii_rx_clk);
            i_udp_axi_checker.end_test($sformatf("%0d", t));
        end
        i_udp_axi_checker.report();
        if (i_udp_axi_checker.failed == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial begin
        repeat ((NUM_TESTS + 1) * TEST_CYCLES) @(posedge gmii_rx_clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 (NUM_TESTS + 1) * TEST_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- build.f
design/udp_axi_pkg.sv
design/sync_fifo.sv
design/udp_cmd_parser.sv
design/axi_wr_master.sv
design/axi_rd_master.sv
design/udp_axi_bridge.sv
testbench/udp_axi_checker.sv
testbench/tb_udp_axi_bridge.sv
